//--- vlog.f
+incdir+include
hw/nic_switch_pkg.sv
hw/axis_ingress_framer.sv
hw/pkt_fifo.sv
hw/axis_egress_steer.sv
hw/nic_switch_top.sv
verification/tb_nic_switch.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_nic_switch \
    -o tb_nic_switch

./obj_dir/tb_nic_switch | tee sim.log

if grep -q "^Verification passed$" sim.log; then
    echo "run_sim: simulation result PASS"
    exit 0
else
    echo "run_sim: simulation result FAIL"
    exit 1
fi

//--- verification/nic_switch_vectors.txt
# I tdata tkeep tlast tdest err : one ingress beat, tdata and tkeep in hex
# E port tdata tkeep tlast err  : expected egress beat, port 0 is line, 1 is host
# C line host drop oversize err : expected final counter values in hex
I 0a00000000000001 ff 0 0 0
I 0a00000000000002 0f 1 0 0
E 0 0a00000000000001 ff 0 0
E 0 0a00000000000002 0f 1 0
I 0b00000000000001 ff 1 2 0
I 0c00000000000001 ff 0 1 1
I 0c00000000000002 3f 1 1 0
E 1 0c00000000000001 ff 0 1
E 1 0c00000000000002 3f 1 0
I 0d00000000000001 ff 0 1 0
I 0d00000000000002 ff 0 0 0
I 0d00000000000003 01 1 3 0
E 1 0d00000000000001 ff 0 0
E 1 0d00000000000002 ff 0 0
E 1 0d00000000000003 01 1 0
I 0e00000000000001 ff 0 3 0
I 0e00000000000002 ff 1 3 0
I 0f00000000000001 ff 0 0 0
I 0f00000000000002 ff 0 0 0
I 0f00000000000003 ff 0 0 0
I 0f00000000000004 ff 0 0 0
I 0f00000000000005 ff 0 0 0
I 0f00000000000006 ff 0 0 0
I 0f00000000000007 ff 0 0 0
I 0f00000000000008 ff 0 0 0
I 0f00000000000009 ff 1 0 0
E 0 0f00000000000001 ff 0 0
E 0 0f00000000000002 ff 0 0
E 0 0f00000000000003 ff 0 0
E 0 0f00000000000004 ff 0 0
E 0 0f00000000000005 ff 0 0
E 0 0f00000000000006 ff 0 0
E 0 0f00000000000007 ff 0 0
E 0 0f00000000000008 ff 1 0
C 0002 0002 0002 0001 0001

//--- verification/tb_nic_switch.sv
`default_nettype none
`include "nic_switch_settings.svh"

module tb_nic_switch;
    import nic_switch_pkg::*;

    localparam int KEEP_WID = `NS_DATA_WID / 8;
    localparam int KEEP_LO  = `NS_DATA_WID;
    localparam int LAST_BIT = `NS_DATA_WID + KEEP_WID;
    localparam int ERR_BIT  = LAST_BIT + 1;
    localparam int BEAT_WID = ERR_BIT + 1;
    localparam string VEC_FILE = "verification/nic_switch_vectors.txt";

    // Beat packed as {err, last, keep, data}
    typedef logic [BEAT_WID-1:0] beat_t;

    logic                      clk;
    logic                      reset;
    logic                      s_axis_tvalid;
    logic [`NS_DATA_WID-1:0]   s_axis_tdata;
    logic [KEEP_WID-1:0]       s_axis_tkeep;
    logic                      s_axis_tlast;
    dest_e                     s_axis_tdest;
    logic                      s_axis_tuser_err;
    logic                      s_axis_tready;
    logic                      m_axis_line_tx_tvalid;
    logic [`NS_DATA_WID-1:0]   m_axis_line_tx_tdata;
    logic [KEEP_WID-1:0]       m_axis_line_tx_tkeep;
    logic                      m_axis_line_tx_tlast;
    logic                      m_axis_line_tx_tuser_err;
    logic                      m_axis_line_tx_tready;
    logic                      m_axis_host_rx_tvalid;
    logic [`NS_DATA_WID-1:0]   m_axis_host_rx_tdata;
    logic [KEEP_WID-1:0]       m_axis_host_rx_tkeep;
    logic                      m_axis_host_rx_tlast;
    logic                      m_axis_host_rx_tuser_err;
    logic                      m_axis_host_rx_tready;
    logic [`NS_CNT_WID-1:0]    line_pkt_count;
    logic [`NS_CNT_WID-1:0]    host_pkt_count;
    logic [`NS_CNT_WID-1:0]    drop_pkt_count;
    logic [`NS_CNT_WID-1:0]    oversize_pkt_count;
    logic [`NS_CNT_WID-1:0]    err_pkt_count;

    // Stimulus, expected and observed beats
    beat_t in_beat_q[$];
    dest_e in_dest_q[$];
    beat_t exp_line_q[$];
    beat_t exp_host_q[$];
    beat_t got_line_q[$];
    beat_t got_host_q[$];

    // Expected counters in the order line, host, drop, oversize, err
    logic [`NS_CNT_WID-1:0] exp_cnt [5];
    logic                   have_counts = 1'b0;

    int n_pass      = 0;
    int n_fail      = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    nic_switch_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    //========================================
    // Vector file and compare helpers
    //========================================
    function automatic string beat_text(input beat_t b);
        return $sformatf("data %h keep %h last %0d err %0d", b[`NS_DATA_WID-1:0],
                         b[KEEP_LO +: KEEP_WID], b[LAST_BIT], b[ERR_BIT]);
    endfunction

    task automatic read_vectors;
        int                      fd;
        int                      code;
        string                   line;
        logic [`NS_DATA_WID-1:0] f_data;
        logic [KEEP_WID-1:0]     f_keep;
        int                      f_port;
        int                      f_last;
        int                      f_dest;
        int                      f_err;
        logic [`NS_CNT_WID-1:0]  c_line;
        logic [`NS_CNT_WID-1:0]  c_host;
        logic [`NS_CNT_WID-1:0]  c_drop;
        logic [`NS_CNT_WID-1:0]  c_over;
        logic [`NS_CNT_WID-1:0]  c_err;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("cannot open vector file %s", VEC_FILE);
            n_fail++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                case (line.getc(0))
                    "I": begin
                        code = $sscanf(line.substr(1, line.len() - 1), "%h %h %d %d %d",
                                       f_data, f_keep, f_last, f_dest, f_err);
                        in_beat_q.push_back({f_err != 0, f_last != 0, f_keep, f_data});
                        in_dest_q.push_back(dest_e'(f_dest[1:0]));
                    end
                    "E": begin
                        code = $sscanf(line.substr(1, line.len() - 1), "%d %h %h %d %d",
                                       f_port, f_data, f_keep, f_last, f_err);
                        if (f_port == 0) begin
                            exp_line_q.push_back({f_err != 0, f_last != 0, f_keep, f_data});
                        end else begin
                            exp_host_q.push_back({f_err != 0, f_last != 0, f_keep, f_data});
                        end
                    end
                    "C": begin
                        code = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                                       c_line, c_host, c_drop, c_over, c_err);
                        exp_cnt[0]  = c_line;
                        exp_cnt[1]  = c_host;
                        exp_cnt[2]  = c_drop;
                        exp_cnt[3]  = c_over;
                        exp_cnt[4]  = c_err;
                        have_counts = 1'b1;
                    end
                    default: code = 5;
                endcase
                if (code != 5) begin
                    $display("malformed vector line: %s", line);
                    n_fail++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_beat(input dest_e port, input int idx,
                              input beat_t exp_b, input beat_t act_b);
        string name;
        name = $sformatf("%s beat %0d", port.name(), idx);
        if (act_b === exp_b) begin
            n_pass++;
            $display("ok: %s", name);
        end else begin
            n_fail++;
            $display("error: %s expected %s actual %s", name, beat_text(exp_b),
                     beat_text(act_b));
        end
    endtask

    task automatic check_count(input string name, input logic [`NS_CNT_WID-1:0] exp_v,
                               input logic [`NS_CNT_WID-1:0] act_v);
        if (act_v === exp_v) begin
            n_pass++;
            $display("ok: %s", name);
        end else begin
            n_fail++;
            $display("error: %s expected %0d actual %0d", name, exp_v, act_v);
        end
    endtask

    task automatic compare_port(input dest_e port, input beat_t exp_q[$],
                                input beat_t got_q[$]);
        for (int i = 0; i < exp_q.size(); i++) begin
            if (i < got_q.size()) begin
                check_beat(port, i, exp_q[i], got_q[i]);
            end else begin
                n_fail++;
                $display("%s beat %0d never arrived", port.name(), i);
            end
        end
        if (got_q.size() > exp_q.size()) begin
            n_fail++;
            $display("%s port delivered %0d beats more than expected", port.name(),
                     got_q.size() - exp_q.size());
        end
    endtask

    // Ready is sampled here, the beat moves on the next rising edge
    task automatic send_beat(input beat_t b, input dest_e d);
        @(negedge clk);
        s_axis_tvalid    = 1'b1;
        s_axis_tdata     = b[`NS_DATA_WID-1:0];
        s_axis_tkeep     = b[KEEP_LO +: KEEP_WID];
        s_axis_tlast     = b[LAST_BIT];
        s_axis_tuser_err = b[ERR_BIT];
        s_axis_tdest     = d;
        while (!s_axis_tready) @(negedge clk);
    endtask

    //========================================
    // Egress back-pressure and monitors
    //========================================
    initial begin : egress_side
        void'($urandom(32'hc2bc_e632));
        forever begin
            @(negedge clk);
            m_axis_line_tx_tready = ($urandom % 2) == 0;
            m_axis_host_rx_tready = ($urandom % 2) == 0;
            // Valid and ready now hold until the next rising edge
            if (!reset) begin
                if (m_axis_line_tx_tvalid === 1'b1 && m_axis_line_tx_tready) begin
                    got_line_q.push_back({m_axis_line_tx_tuser_err, m_axis_line_tx_tlast,
                                          m_axis_line_tx_tkeep, m_axis_line_tx_tdata});
                end
                if (m_axis_host_rx_tvalid === 1'b1 && m_axis_host_rx_tready) begin
                    got_host_q.push_back({m_axis_host_rx_tuser_err, m_axis_host_rx_tlast,
                                          m_axis_host_rx_tkeep, m_axis_host_rx_tdata});
                end
            end
        end
    end

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) @(negedge clk);
        $display("run stalled: egress did not finish within %0d cycles", cycle_limit);
        $display("Verification failed");
        $finish;
    end

    //========================================
    // Main sequence
    //========================================
    initial begin : main_seq
        reset                 = 1'b1;
        s_axis_tvalid         = 1'b0;
        s_axis_tdata          = '0;
        s_axis_tkeep          = '0;
        s_axis_tlast          = 1'b0;
        s_axis_tdest          = DEST_LINE;
        s_axis_tuser_err      = 1'b0;
        m_axis_line_tx_tready = 1'b0;
        m_axis_host_rx_tready = 1'b0;

        read_vectors();
        cycle_limit = 20 * in_beat_q.size() + 100;

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        foreach (in_beat_q[i]) begin
            send_beat(in_beat_q[i], in_dest_q[i]);
        end
        @(negedge clk);
        s_axis_tvalid = 1'b0;

        while (got_line_q.size() < exp_line_q.size() ||
               got_host_q.size() < exp_host_q.size()) begin
            @(negedge clk);
        end
        // Let counters settle and catch any extra beats
        repeat (4) @(negedge clk);

        compare_port(DEST_LINE, exp_line_q, got_line_q);
        compare_port(DEST_HOST, exp_host_q, got_host_q);
        if (have_counts) begin
            check_count("line_pkt_count", exp_cnt[0], line_pkt_count);
            check_count("host_pkt_count", exp_cnt[1], host_pkt_count);
            check_count("drop_pkt_count", exp_cnt[2], drop_pkt_count);
            check_count("oversize_pkt_count", exp_cnt[3], oversize_pkt_count);
            check_count("err_pkt_count", exp_cnt[4], err_pkt_count);
        end else begin
            n_fail++;
            $display("vector file has no counter line");
        end

        $display("tests: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_nic_switch

`default_nettype wire

//--- hw/nic_switch_top.sv
`default_nettype none
`include "nic_switch_settings.svh"

module nic_switch_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        s_axis_tvalid,
    input  logic [`NS_DATA_WID-1:0]     s_axis_tdata,
    input  logic [`NS_DATA_WID/8-1:0]   s_axis_tkeep,
    input  logic                        s_axis_tlast,
    input  nic_switch_pkg::dest_e       s_axis_tdest,
    input  logic                        s_axis_tuser_err,
    output logic                        s_axis_tready,
    output logic                        m_axis_line_tx_tvalid,
    output logic [`NS_DATA_WID-1:0]     m_axis_line_tx_tdata,
    output logic [`NS_DATA_WID/8-1:0]   m_axis_line_tx_tkeep,
    output logic                        m_axis_line_tx_tlast,
    output logic                        m_axis_line_tx_tuser_err,
    input  logic                        m_axis_line_tx_tready,
    output logic                        m_axis_host_rx_tvalid,
    output logic [`NS_DATA_WID-1:0]     m_axis_host_rx_tdata,
    output logic [`NS_DATA_WID/8-1:0]   m_axis_host_rx_tkeep,
    output logic                        m_axis_host_rx_tlast,
    output logic                        m_axis_host_rx_tuser_err,
    input  logic                        m_axis_host_rx_tready,
    output logic [`NS_CNT_WID-1:0]      line_pkt_count,
    output logic [`NS_CNT_WID-1:0]      host_pkt_count,
    output logic [`NS_CNT_WID-1:0]      drop_pkt_count,
    output logic [`NS_CNT_WID-1:0]      oversize_pkt_count,
    output logic [`NS_CNT_WID-1:0]      err_pkt_count
);
    import nic_switch_pkg::*;

    // Framer to FIFO
    logic                      wr_valid;
    logic                      wr_ready;
    logic [`NS_DATA_WID-1:0]   wr_data;
    logic [`NS_DATA_WID/8-1:0] wr_keep;
    logic                      wr_last;
    logic                      wr_err;
    dest_e                     wr_dest;
    logic                      oversize_pulse;

    // FIFO to steering stage
    logic                      rd_valid;
    logic                      rd_ready;
    logic [`NS_DATA_WID-1:0]   rd_data;
    logic [`NS_DATA_WID/8-1:0] rd_keep;
    logic                      rd_last;
    logic                      rd_err;
    dest_e                     rd_dest;

    axis_ingress_framer u_framer (
        .clk, .reset,
        .s_axis_tvalid, .s_axis_tdata, .s_axis_tkeep, .s_axis_tlast,
        .s_axis_tdest, .s_axis_tuser_err, .s_axis_tready,
        .wr_valid, .wr_data, .wr_keep, .wr_last, .wr_err, .wr_dest,
        .wr_ready, .oversize_pulse
    );

    pkt_fifo u_fifo (
        .clk, .reset,
        .wr_valid, .wr_ready, .wr_data, .wr_keep, .wr_last, .wr_err, .wr_dest,
        .rd_valid, .rd_ready, .rd_data, .rd_keep, .rd_last, .rd_err, .rd_dest
    );

    axis_egress_steer u_steer (
        .clk, .reset,
        .rd_valid, .rd_ready, .rd_data, .rd_keep, .rd_last, .rd_err, .rd_dest,
        .oversize_pulse,
        .m_axis_line_tx_tvalid, .m_axis_line_tx_tdata, .m_axis_line_tx_tkeep,
        .m_axis_line_tx_tlast, .m_axis_line_tx_tuser_err, .m_axis_line_tx_tready,
        .m_axis_host_rx_tvalid, .m_axis_host_rx_tdata, .m_axis_host_rx_tkeep,
        .m_axis_host_rx_tlast, .m_axis_host_rx_tuser_err, .m_axis_host_rx_tready,
        .line_pkt_count, .host_pkt_count, .drop_pkt_count,
        .oversize_pkt_count, .err_pkt_count
    );

endmodule : nic_switch_top

`default_nettype wire

//--- hw/axis_egress_steer.sv
`default_nettype none
`include "nic_switch_settings.svh"

module axis_egress_steer (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        rd_valid,
    output logic                        rd_ready,
    input  logic [`NS_DATA_WID-1:0]     rd_data,
    input  logic [`NS_DATA_WID/8-1:0]   rd_keep,
    input  logic                        rd_last,
    input  logic                        rd_err,
    input  nic_switch_pkg::dest_e       rd_dest,
    input  logic                        oversize_pulse,
    output logic                        m_axis_line_tx_tvalid,
    output logic [`NS_DATA_WID-1:0]     m_axis_line_tx_tdata,
    output logic [`NS_DATA_WID/8-1:0]   m_axis_line_tx_tkeep,
    output logic                        m_axis_line_tx_tlast,
    output logic                        m_axis_line_tx_tuser_err,
    input  logic                        m_axis_line_tx_tready,
    output logic                        m_axis_host_rx_tvalid,
    output logic [`NS_DATA_WID-1:0]     m_axis_host_rx_tdata,
    output logic [`NS_DATA_WID/8-1:0]   m_axis_host_rx_tkeep,
    output logic                        m_axis_host_rx_tlast,
    output logic                        m_axis_host_rx_tuser_err,
    input  logic                        m_axis_host_rx_tready,
    output logic [`NS_CNT_WID-1:0]      line_pkt_count,
    output logic [`NS_CNT_WID-1:0]      host_pkt_count,
    output logic [`NS_CNT_WID-1:0]      drop_pkt_count,
    output logic [`NS_CNT_WID-1:0]      oversize_pkt_count,
    output logic [`NS_CNT_WID-1:0]      err_pkt_count
);
    import nic_switch_pkg::*;

    logic to_line;
    logic to_host;
    logic rd_xfer;
    logic err_seen;
    logic pkt_err;

    //========================================
    // Port select
    //========================================
    assign to_line = (rd_dest == DEST_LINE);
    assign to_host = (rd_dest == DEST_HOST);

    always_comb begin
        case (rd_dest)
            DEST_LINE: rd_ready = m_axis_line_tx_tready;
            DEST_HOST: rd_ready = m_axis_host_rx_tready;
            default:   rd_ready = 1'b1;
        endcase
    end

    assign rd_xfer = rd_valid && rd_ready;

    // Payload fans out to both ports, only tvalid is steered
    assign m_axis_line_tx_tvalid    = rd_valid && to_line;
    assign m_axis_line_tx_tdata     = rd_data;
    assign m_axis_line_tx_tkeep     = rd_keep;
    assign m_axis_line_tx_tlast     = rd_last;
    assign m_axis_line_tx_tuser_err = rd_err;

    assign m_axis_host_rx_tvalid    = rd_valid && to_host;
    assign m_axis_host_rx_tdata     = rd_data;
    assign m_axis_host_rx_tkeep     = rd_keep;
    assign m_axis_host_rx_tlast     = rd_last;
    assign m_axis_host_rx_tuser_err = rd_err;

    //========================================
    // Status counters
    //========================================
    assign pkt_err = err_seen || rd_err;

    always_ff @(posedge clk) begin
        if (reset) begin
            err_seen           <= 1'b0;
            line_pkt_count     <= '0;
            host_pkt_count     <= '0;
            drop_pkt_count     <= '0;
            oversize_pkt_count <= '0;
            err_pkt_count      <= '0;
        end else begin
            if (oversize_pulse) oversize_pkt_count <= oversize_pkt_count + 1'b1;
            if (rd_xfer) begin
                // Error flag holds until the packet ends
                err_seen <= rd_last ? 1'b0 : pkt_err;
                if (rd_last) begin
                    if (to_line) line_pkt_count <= line_pkt_count + 1'b1;
                    else if (to_host) host_pkt_count <= host_pkt_count + 1'b1;
                    else drop_pkt_count <= drop_pkt_count + 1'b1;
                    if ((to_line || to_host) && pkt_err) begin
                        err_pkt_count <= err_pkt_count + 1'b1;
                    end
                end
            end
        end
    end

    // Stalled egress beats must hold until taken
    a_line_hold: assert property (@(posedge clk) disable iff (reset)
        m_axis_line_tx_tvalid && !m_axis_line_tx_tready |=>
            m_axis_line_tx_tvalid && $stable(m_axis_line_tx_tdata));
    a_host_hold: assert property (@(posedge clk) disable iff (reset)
        m_axis_host_rx_tvalid && !m_axis_host_rx_tready |=>
            m_axis_host_rx_tvalid && $stable(m_axis_host_rx_tdata));

endmodule : axis_egress_steer

`default_nettype wire

//--- hw/pkt_fifo.sv
`default_nettype none
`include "nic_switch_settings.svh"

module pkt_fifo (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        wr_valid,
    output logic                        wr_ready,
    input  logic [`NS_DATA_WID-1:0]     wr_data,
    input  logic [`NS_DATA_WID/8-1:0]   wr_keep,
    input  logic                        wr_last,
    input  logic                        wr_err,
    input  nic_switch_pkg::dest_e       wr_dest,
    output logic                        rd_valid,
    input  logic                        rd_ready,
    output logic [`NS_DATA_WID-1:0]     rd_data,
    output logic [`NS_DATA_WID/8-1:0]   rd_keep,
    output logic                        rd_last,
    output logic                        rd_err,
    output nic_switch_pkg::dest_e       rd_dest
);
    import nic_switch_pkg::*;

    localparam int DEPTH    = `NS_FIFO_DEPTH;
    localparam int PTR_WID  = $clog2(DEPTH);
    localparam int KEEP_WID = `NS_DATA_WID / 8;

    // Beat storage
    logic [`NS_DATA_WID-1:0] mem_data [DEPTH];
    logic [KEEP_WID-1:0]     mem_keep [DEPTH];
    logic                    mem_last [DEPTH];
    logic                    mem_err  [DEPTH];
    dest_e                   mem_dest [DEPTH];

    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [PTR_WID:0]   count;
    logic               wr_xfer;
    logic               rd_xfer;

    assign wr_ready = (count != (PTR_WID + 1)'(DEPTH));
    assign rd_valid = (count != '0);
    assign wr_xfer  = wr_valid && wr_ready;
    assign rd_xfer  = rd_valid && rd_ready;

    // Output comes straight from the storage registers at the read pointer
    assign rd_data = mem_data[rd_ptr];
    assign rd_keep = mem_keep[rd_ptr];
    assign rd_last = mem_last[rd_ptr];
    assign rd_err  = mem_err[rd_ptr];
    assign rd_dest = mem_dest[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_xfer) begin
            mem_data[wr_ptr] <= wr_data;
            mem_keep[wr_ptr] <= wr_keep;
            mem_last[wr_ptr] <= wr_last;
            mem_err[wr_ptr]  <= wr_err;
            mem_dest[wr_ptr] <= wr_dest;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_xfer) wr_ptr <= wr_ptr + 1'b1;
            if (rd_xfer) rd_ptr <= rd_ptr + 1'b1;
            // Push and pop together leave the count alone
            if (wr_xfer && !rd_xfer) begin
                count <= count + 1'b1;
            end else if (rd_xfer && !wr_xfer) begin
                count <= count - 1'b1;
            end
        end
    end

    // Occupancy stays within the depth and agrees with the pointer distance
    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        (count <= (PTR_WID + 1)'(DEPTH)) &&
            (PTR_WID'(wr_ptr - rd_ptr) == count[PTR_WID-1:0]));

endmodule : pkt_fifo

`default_nettype wire

//--- hw/axis_ingress_framer.sv
`default_nettype none
`include "nic_switch_settings.svh"

module axis_ingress_framer (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        s_axis_tvalid,
    input  logic [`NS_DATA_WID-1:0]     s_axis_tdata,
    input  logic [`NS_DATA_WID/8-1:0]   s_axis_tkeep,
    input  logic                        s_axis_tlast,
    input  nic_switch_pkg::dest_e       s_axis_tdest,
    input  logic                        s_axis_tuser_err,
    output logic                        s_axis_tready,
    output logic                        wr_valid,
    output logic [`NS_DATA_WID-1:0]     wr_data,
    output logic [`NS_DATA_WID/8-1:0]   wr_keep,
    output logic                        wr_last,
    output logic                        wr_err,
    output nic_switch_pkg::dest_e       wr_dest,
    input  logic                        wr_ready,
    output logic                        oversize_pulse
);
    import nic_switch_pkg::*;

    localparam int CNT_WID = $clog2(`NS_MAX_BEATS + 1);

    framer_state_e        state;
    logic [CNT_WID-1:0]   beat_cnt;
    dest_e                dest_q;
    logic                 wr_xfer;
    logic                 at_max;

    // Beats already accepted in this packet, so the limit beat is at MAX-1
    assign at_max  = (beat_cnt == CNT_WID'(`NS_MAX_BEATS - 1));
    assign wr_xfer = wr_valid && wr_ready;

    // Tail of a truncated packet is swallowed without touching the FIFO
    assign s_axis_tready = (state == FR_DISCARD) ? 1'b1 : wr_ready;
    assign wr_valid      = s_axis_tvalid && (state != FR_DISCARD);
    assign wr_data       = s_axis_tdata;
    assign wr_keep       = s_axis_tkeep;
    assign wr_err        = s_axis_tuser_err;
    assign wr_last       = s_axis_tlast || at_max;
    assign wr_dest       = (state == FR_IDLE) ? s_axis_tdest : dest_q;

    assign oversize_pulse = wr_xfer && at_max && !s_axis_tlast;

    always_ff @(posedge clk) begin
        if (state == FR_IDLE && wr_xfer) begin
            dest_q <= s_axis_tdest;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= FR_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                FR_IDLE, FR_IN_PKT: begin
                    if (wr_xfer) begin
                        if (s_axis_tlast) begin
                            state    <= FR_IDLE;
                            beat_cnt <= '0;
                        end else if (at_max) begin
                            state    <= FR_DISCARD;
                            beat_cnt <= '0;
                        end else begin
                            state    <= FR_IN_PKT;
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                FR_DISCARD: begin
                    // Wait for the real end of the oversize packet
                    if (s_axis_tvalid && s_axis_tlast) begin
                        state <= FR_IDLE;
                    end
                end
                default: begin
                    state    <= FR_IDLE;
                    beat_cnt <= '0;
                end
            endcase
        end
    end

    // A stalled write keeps its beat, destination and last until the FIFO takes it
    a_wr_hold: assert property (@(posedge clk) disable iff (reset)
        wr_valid && !wr_ready |=>
            wr_valid && $stable(wr_data) && $stable(wr_dest) && $stable(wr_last));

endmodule : axis_ingress_framer

`default_nettype wire

//--- hw/nic_switch_pkg.sv
`default_nettype none

package nic_switch_pkg;

    //========================================
    // Packet destination from first-beat tdest
    //========================================
    typedef enum logic [1:0] {
        DEST_LINE   = 2'd0,
        DEST_HOST   = 2'd1,
        DEST_DROP_2 = 2'd2,
        DEST_DROP_3 = 2'd3
    } dest_e;

    //========================================
    // Ingress framer states
    //========================================
    typedef enum logic [1:0] {
        FR_IDLE    = 2'd0,
        FR_IN_PKT  = 2'd1,
        FR_DISCARD = 2'd2
    } framer_state_e;

endpackage : nic_switch_pkg

`default_nettype wire

//--- include/nic_switch_settings.svh
`ifndef NIC_SWITCH_SETTINGS_SVH
`define NIC_SWITCH_SETTINGS_SVH

// Stream data width in bits, tkeep is one bit per byte
`define NS_DATA_WID 64

// Beat FIFO entries, must be a power of two
`define NS_FIFO_DEPTH 16

// Longest packet passed before truncation, in beats
`define NS_MAX_BEATS 8

// Width of each status counter
`define NS_CNT_WID 16

`endif
